//--- verilog/iq_params.svh
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// queue geometry
`define IQ_SIZE      16 // total slots, half per column
`define IQ_DISP_W    4  // dispatch lanes, two per column

// field widths
`define IQ_REG_W     5  // physical register index
`define IQ_TAG_W     5  // reorder tag, also the age tag
`define IQ_BRM_W     3  // one bit per unresolved branch
`define IQ_OPC_W     7

// result broadcast
`define IQ_WB_PORTS  4

`endif

//--- verilog/iq_pkg.sv
`include "iq_params.svh"

package iq_pkg;

	typedef logic [`IQ_REG_W-1:0] preg_t;
	typedef logic [`IQ_TAG_W-1:0] rob_tag_t;
	typedef logic [`IQ_BRM_W-1:0] br_mask_t;
	typedef logic [`IQ_OPC_W-1:0] opcode_t;

	// one renamed micro-op as it arrives from rename
	typedef struct packed {
		logic     valid;   // lane carries an op
		opcode_t  opcode;
		br_mask_t br_mask;
		rob_tag_t tag;
		preg_t    dest;
		preg_t    src1;
		preg_t    src2;
	} disp_op_t;

	typedef struct packed {
		disp_op_t op;
		logic     src1_rdy;
		logic     src2_rdy;
	} iq_entry_t;

	// what leaves the queue, no flag bits
	typedef struct packed {
		opcode_t  opcode;
		br_mask_t br_mask;
		rob_tag_t tag;
		preg_t    dest;
		preg_t    src1;
		preg_t    src2;
	} issue_op_t;

	// result tags broadcast by the writeback ports
	typedef struct packed {
		logic  [`IQ_WB_PORTS-1:0] valid;
		preg_t [`IQ_WB_PORTS-1:0] preg;
	} wb_bus_t;

endpackage

//--- verilog/oldest_select.sv
`timescale 1ns/1ns
`include "iq_params.svh"

// entries drain toward index 0, so the lowest requesting index is the oldest
module oldest_select #(
	parameter int NUM = `IQ_SIZE / 2
) (
	input  logic [NUM-1:0] i_request,
	output logic [NUM-1:0] o_grant,   // one-hot, zero when nothing requests
	output logic           o_empty
);

	assign o_empty = ~|i_request;

	// walk down so the lowest set request is the last one written
	always_comb begin
		o_grant = '0;
		for (int i = NUM - 1; i >= 0; i--) begin
			if (i_request[i])
				o_grant = NUM'(1) << i;
		end
	end

	always_comb begin
		assert ($onehot0(o_grant) && (o_grant & ~i_request) == '0)
		else $error("select grant is not one-hot or not requested");
	end

endmodule

//--- verilog/issue_slot.sv
`timescale 1ns/1ns
`include "iq_params.svh"

module issue_slot (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  iq_pkg::iq_entry_t i_move,        // entry above, or a dispatch lane at the top
	input  logic              i_shift,
	input  logic              i_grant,
	input  logic              i_issue_ready,
	input  iq_pkg::wb_bus_t   i_wb,
	input  iq_pkg::br_mask_t  i_br_kill,
	output iq_pkg::iq_entry_t o_entry,       // contents with this cycle's kill and grant
	output logic              o_request,
	output logic              o_free
);
	import iq_pkg::*;

	iq_entry_t slot_q;
	iq_entry_t slot_d;
	logic      killed;
	logic      leaving;

	// apply this cycle's wakeup broadcast and branch kill to an entry
	function automatic iq_entry_t update(input iq_entry_t e);
		iq_entry_t r;
		r = e;
		for (int p = 0; p < `IQ_WB_PORTS; p++) begin
			if (i_wb.valid[p] && i_wb.preg[p] == e.op.src1)
				r.src1_rdy = 1'b1;
			if (i_wb.valid[p] && i_wb.preg[p] == e.op.src2)
				r.src2_rdy = 1'b1;
		end
		if ((e.op.br_mask & i_br_kill) != '0)
			r.op.valid = 1'b0; // speculative on a killed branch
		return r;
	endfunction

	assign killed  = (slot_q.op.br_mask & i_br_kill) != '0;
	assign leaving = i_grant & i_issue_ready;

	// the slot below must not pick up an op that issues or dies now
	always_comb begin
		o_entry          = slot_q;
		o_entry.op.valid = slot_q.op.valid & ~killed & ~leaving;
	end

	// ready bits are registered, so wakeup to request is one edge
	assign o_request = slot_q.op.valid & ~killed & slot_q.src1_rdy & slot_q.src2_rdy;
	assign o_free    = ~slot_q.op.valid | killed | i_grant;

	always_comb begin
		if (i_shift && i_issue_ready)
			slot_d = update(i_move);  // collapse step
		else
			slot_d = update(o_entry); // hold, wakeup and kill in place
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			slot_q <= '0;
		else
			slot_q <= slot_d;
	end

	// the selector only grants a live entry whose sources are both ready
	a_grant_needs_request: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_grant |-> (o_request && slot_q.op.valid))
		else $error("slot granted without a valid request");

endmodule

//--- verilog/issue_queue.sv
`timescale 1ns/1ns
`include "iq_params.svh"

// two columns, each one even and one odd chain interleaved by slot index
module issue_queue (
	input  logic                                 i_clk,
	input  logic                                 i_arst_n,
	input  iq_pkg::iq_entry_t [`IQ_DISP_W-1:0]   i_ins,
	input  iq_pkg::wb_bus_t                      i_wb,
	input  iq_pkg::br_mask_t                     i_br_kill,
	input  logic                                 i_issue_ready,
	output logic                                 o_disp_ready,
	output iq_pkg::issue_op_t [1:0]              o_issue_ops,
	output logic [1:0]                           o_issue_valid
);
	import iq_pkg::*;

	localparam int COL = `IQ_SIZE / 2; // slots per column

	iq_entry_t      ent     [2][COL+2]; // slot outputs, plus the two lanes on top
	logic [COL-1:0] request [2];
	logic [COL-1:0] grant   [2];
	logic [COL-1:0] free    [2];
	logic [COL-1:0] shift   [2];
	logic [1:0]     empty;
	iq_entry_t      pick    [2];

	for (genvar c = 0; c < 2; c++) begin : g_col
		assign ent[c][COL]   = i_ins[c];     // lanes 0,1 feed the even chains
		assign ent[c][COL+1] = i_ins[c + 2]; // lanes 2,3 feed the odd chains

		for (genvar i = 0; i < COL; i++) begin : g_slot
			// a hole anywhere below pulls the rest of the chain down
			if (i < 2) begin : g_base
				assign shift[c][i] = free[c][i];
			end else begin : g_up
				assign shift[c][i] = free[c][i] | shift[c][i-2];
			end

			issue_slot u_slot (
				.i_clk         (i_clk),
				.i_arst_n      (i_arst_n),
				.i_move        (ent[c][i+2]),
				.i_shift       (shift[c][i]),
				.i_grant       (grant[c][i]),
				.i_issue_ready (i_issue_ready),
				.i_wb          (i_wb),
				.i_br_kill     (i_br_kill),
				.o_entry       (ent[c][i]),
				.o_request     (request[c][i]),
				.o_free        (free[c][i])
			);
		end

		oldest_select #(.NUM(COL)) u_sel (
			.i_request (request[c]),
			.o_grant   (grant[c]),
			.o_empty   (empty[c])
		);

		assign o_issue_valid[c]       = ~empty[c];
		assign o_issue_ops[c].opcode  = pick[c].op.opcode;
		assign o_issue_ops[c].br_mask = pick[c].op.br_mask;
		assign o_issue_ops[c].tag     = pick[c].op.tag;
		assign o_issue_ops[c].dest    = pick[c].op.dest;
		assign o_issue_ops[c].src1    = pick[c].op.src1;
		assign o_issue_ops[c].src2    = pick[c].op.src2;

		// a stalled offer is still there next cycle unless a kill hits
		a_stall_keeps_offer: assert property (@(posedge i_clk) disable iff (!i_arst_n)
			(o_issue_valid[c] && !i_issue_ready && i_br_kill == '0)
				|=> (o_issue_valid[c] || i_br_kill != '0))
			else $error("column %0d lost its offer during a stall", c);
	end

	// grant mux, grants are one-hot
	always_comb begin
		for (int c = 0; c < 2; c++) begin
			pick[c] = '0;
			for (int i = 0; i < COL; i++) begin
				if (grant[c][i])
					pick[c] = ent[c][i];
			end
		end
	end

	// room for a full group only when every chain opens its top slot
	assign o_disp_ready = i_issue_ready
	                    & shift[0][COL-2] & shift[0][COL-1]
	                    & shift[1][COL-2] & shift[1][COL-1];

	a_stall_blocks_disp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!i_issue_ready |-> !o_disp_ready)
		else $error("dispatch accepted while issue is stalled");

endmodule

//--- verilog/reg_ready_table.sv
`timescale 1ns/1ns
`include "iq_params.svh"

module reg_ready_table (
	input  logic                                i_clk,
	input  logic                                i_arst_n,
	input  iq_pkg::disp_op_t [`IQ_DISP_W-1:0]   i_disp_ops,
	input  logic                                i_disp_fire,
	input  iq_pkg::wb_bus_t                     i_wb,
	output iq_pkg::iq_entry_t [`IQ_DISP_W-1:0]  o_ins
);
	import iq_pkg::*;

	localparam int NREG = 1 << `IQ_REG_W;

	logic [NREG-1:0] pending_q; // set while a result is outstanding
	logic [NREG-1:0] pending_d;

	// ready if not pending or written this cycle, and no older lane in the group writes it
	function automatic logic src_ready(input int lane, input preg_t r);
		logic rdy;
		rdy = ~pending_q[r];
		for (int p = 0; p < `IQ_WB_PORTS; p++) begin
			if (i_wb.valid[p] && i_wb.preg[p] == r)
				rdy = 1'b1;
		end
		for (int j = 0; j < `IQ_DISP_W; j++) begin
			if (j < lane && i_disp_ops[j].valid && i_disp_ops[j].dest == r)
				rdy = 1'b0;
		end
		return rdy;
	endfunction

	always_comb begin
		for (int k = 0; k < `IQ_DISP_W; k++) begin
			o_ins[k].op       = i_disp_ops[k];
			o_ins[k].op.valid = i_disp_ops[k].valid & i_disp_fire; // empty unless transferred
			o_ins[k].src1_rdy = src_ready(k, i_disp_ops[k].src1);
			o_ins[k].src2_rdy = src_ready(k, i_disp_ops[k].src2);
		end
	end

	always_comb begin
		pending_d = pending_q;
		for (int p = 0; p < `IQ_WB_PORTS; p++) begin
			if (i_wb.valid[p])
				pending_d[i_wb.preg[p]] = 1'b0;
		end
		// new producer wins over a writeback of the old value
		if (i_disp_fire) begin
			for (int k = 0; k < `IQ_DISP_W; k++) begin
				if (i_disp_ops[k].valid)
					pending_d[i_disp_ops[k].dest] = 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			pending_q <= '0; // all registers ready
		else
			pending_q <= pending_d;
	end

endmodule

//--- verilog/issue_unit.sv
`timescale 1ns/1ns
`include "iq_params.svh"

// issue stage top, ready table in front of the two-column queue
module issue_unit (
	input  logic                               i_clk,
	input  logic                               i_arst_n,
	input  iq_pkg::disp_op_t [`IQ_DISP_W-1:0]  i_disp_ops,
	input  logic                               i_disp_valid,
	output logic                               o_disp_ready,
	input  iq_pkg::wb_bus_t                    i_wb,
	input  iq_pkg::br_mask_t                   i_br_kill,
	input  logic                               i_issue_ready,
	output iq_pkg::issue_op_t [1:0]            o_issue_ops,
	output logic [1:0]                         o_issue_valid
);
	import iq_pkg::*;

	iq_entry_t [`IQ_DISP_W-1:0] ins;       // dispatch group with initial ready bits
	logic                       disp_fire; // group transfers at this edge

	assign disp_fire = i_disp_valid & o_disp_ready;

	reg_ready_table u_table (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_disp_ops  (i_disp_ops),
		.i_disp_fire (disp_fire),
		.i_wb        (i_wb),
		.o_ins       (ins)
	);

	issue_queue u_queue (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_ins         (ins),
		.i_wb          (i_wb),
		.i_br_kill     (i_br_kill),
		.i_issue_ready (i_issue_ready),
		.o_disp_ready  (o_disp_ready),
		.o_issue_ops   (o_issue_ops),
		.o_issue_valid (o_issue_valid)
	);

endmodule

//--- test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int NTAG = 1 << `IQ_TAG_W;
localparam int NREG = 1 << `IQ_REG_W;

logic [31:0]     lfsr_q;
logic [NREG-1:0] reg_pending; // shadow ready table
logic [NTAG-1:0] tag_busy;    // held by a waiting group or in flight
logic [NTAG-1:0] in_flight;
logic [NTAG-1:0] rdy1_of;
logic [NTAG-1:0] rdy2_of;
preg_t           src1_of  [NTAG];
preg_t           src2_of  [NTAG];
br_mask_t        brm_of   [NTAG];
issue_op_t       op_of    [NTAG]; // payload as dispatched
int              chain_of [NTAG]; // dispatch lane, one chain per lane
int              age_of   [NTAG];
int              disp_seq;

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        lsb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lsb = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (lsb)
			lfsr_q = lfsr_q ^ 32'h8020_0003;
		r = {r[30:0], lsb};
	end
	return r;
endfunction

function automatic logic wb_hits(input preg_t r);
	logic hit;
	hit = 1'b0;
	for (int p = 0; p < `IQ_WB_PORTS; p++) begin
		if (wb.valid[p] && wb.preg[p] == r)
			hit = 1'b1;
	end
	return hit;
endfunction

// not pending or written now, and no earlier lane of the group produces it
function automatic logic lane_src_ready(input int lane, input preg_t r);
	logic rdy;
	rdy = !reg_pending[r] || wb_hits(r);
	for (int j = 0; j < lane; j++) begin
		if (disp_ops[j].valid && disp_ops[j].dest == r)
			rdy = 1'b0;
	end
	return rdy;
endfunction

// entries keep their order only inside a chain
function automatic logic older_ready_waiting(input rob_tag_t t);
	logic found;
	found = 1'b0;
	for (int j = 0; j < NTAG; j++) begin
		if (in_flight[j] && j != int'(t) && chain_of[j] == chain_of[t]
				&& age_of[j] < age_of[t] && rdy1_of[j] && rdy2_of[j]
				&& (brm_of[j] & br_kill) == '0)
			found = 1'b1;
	end
	return found;
endfunction

function automatic int inflight_count();
	int n;
	n = 0;
	for (int j = 0; j < NTAG; j++)
		n += int'(in_flight[j]);
	return n;
endfunction

task automatic alloc_tag(output logic ok, output rob_tag_t t);
	int start;
	ok = 1'b0;
	t = '0;
	start = int'(rand_bits(`IQ_TAG_W));
	for (int i = 0; i < NTAG; i++) begin
		if (!ok && !tag_busy[(start + i) % NTAG]) begin
			ok = 1'b1;
			t = rob_tag_t'((start + i) % NTAG);
		end
	end
endtask

task automatic alloc_dest(input logic [NREG-1:0] taken, output logic ok, output preg_t d);
	int start;
	int idx;
	ok = 1'b0;
	d = '0;
	start = int'(rand_bits(`IQ_REG_W));
	for (int i = 0; i < NREG; i++) begin
		idx = (start + i) % NREG;
		if (!ok && !reg_pending[idx] && !taken[idx]) begin
			ok = 1'b1;
			d = preg_t'(idx);
		end
	end
endtask

`endif

//--- test/tb_issue_unit.sv
`timescale 1ns/1ns
`include "iq_params.svh"

module tb_issue_unit;
	import iq_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int RAND_CYCLES = 400;
	localparam int LIMIT_NS    = (RAND_CYCLES + 16 * `IQ_SIZE + 100) * CLK_PERIOD;

	logic                         clk = 1'b0;
	logic                         arst_n;
	disp_op_t [`IQ_DISP_W-1:0]    disp_ops;
	logic                         disp_valid;
	logic                         o_disp_ready;
	wb_bus_t                      wb;
	br_mask_t                     br_kill;
	logic                         issue_ready;
	issue_op_t [1:0]              o_issue_ops;
	logic [1:0]                   o_issue_valid;

	logic       group_waiting; // dispatch group held until it transfers
	logic       transferred;

	// check results, set at the falling edge and asserted at the next rising edge
	logic [1:0] offer_seen;
	logic [1:0] flight_ok;
	logic [1:0] col_ok;
	logic [1:0] live_ok;
	logic [1:0] rdy1_ok;
	logic [1:0] rdy2_ok;
	logic [1:0] order_ok;
	logic [1:0] payload_ok;
	rob_tag_t   off_tag  [2];
	preg_t      off_src1 [2];
	preg_t      off_src2 [2];
	int         off_col  [2];
	issue_op_t  exp_op   [2];
	issue_op_t  got_op   [2];
	logic       idle_valid_ok;
	logic       idle_ready_ok;
	logic       stall_ok;
	logic [1:0] obs_issue_valid;
	logic       obs_disp_ready;

	`include "tb_model.svh"

	issue_unit DUT (
		.i_clk         (clk),
		.i_arst_n      (arst_n),
		.i_disp_ops    (disp_ops),
		.i_disp_valid  (disp_valid),
		.o_disp_ready  (o_disp_ready),
		.i_wb          (wb),
		.i_br_kill     (br_kill),
		.i_issue_ready (issue_ready),
		.o_issue_ops   (o_issue_ops),
		.o_issue_valid (o_issue_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic retire_tag(input rob_tag_t t);
		in_flight[t] = 1'b0;
		tag_busy[t]  = 1'b0;
	endtask

	task automatic build_group();
		logic [NREG-1:0] taken;
		logic            ok_t;
		logic            ok_d;
		rob_tag_t        t;
		preg_t           d;
		taken = '0;
		for (int k = 0; k < `IQ_DISP_W; k++) begin
			disp_ops[k] = '0;
			if (rand_bits(2) != 0) begin
				alloc_tag(ok_t, t);
				alloc_dest(taken, ok_d, d);
				if (ok_t && ok_d) begin
					tag_busy[t] = 1'b1;
					taken[d]    = 1'b1;
					disp_ops[k].valid   = 1'b1;
					disp_ops[k].opcode  = opcode_t'(rand_bits(`IQ_OPC_W));
					disp_ops[k].br_mask = br_mask_t'(rand_bits(3) & rand_bits(3));
					disp_ops[k].tag     = t;
					disp_ops[k].dest    = d;
					disp_ops[k].src1    = preg_t'(rand_bits(`IQ_REG_W));
					disp_ops[k].src2    = preg_t'(rand_bits(`IQ_REG_W));
				end
			end
		end
		group_waiting = 1'b1;
	endtask

	task automatic drive_random();
		preg_t r;
		issue_ready = rand_bits(3) != 0; // stall about one cycle in eight
		br_kill = '0;
		if (rand_bits(4) == 0)
			br_kill = br_mask_t'(1 << (rand_bits(2) % 3));
		wb = '0;
		for (int p = 0; p < `IQ_WB_PORTS; p++) begin
			if (rand_bits(1) != 0) begin
				r = preg_t'(rand_bits(`IQ_REG_W));
				if (reg_pending[r]) begin
					wb.valid[p] = 1'b1;
					wb.preg[p]  = r;
				end
			end
		end
		if (!group_waiting && rand_bits(1) != 0)
			build_group();
		disp_valid = group_waiting;
	endtask

	// no kills or stalls, write back the lowest pending registers
	task automatic drive_drain();
		int n;
		issue_ready = 1'b1;
		br_kill = '0;
		wb = '0;
		n = 0;
		for (int r = 0; r < NREG; r++) begin
			if (reg_pending[r] && n < `IQ_WB_PORTS) begin
				wb.valid[n] = 1'b1;
				wb.preg[n]  = preg_t'(r);
				n++;
			end
		end
		disp_valid = group_waiting;
	endtask

	task automatic observe();
		rob_tag_t              t;
		logic                  fire;
		logic [`IQ_DISP_W-1:0] r1;
		logic [`IQ_DISP_W-1:0] r2;
		fire = disp_valid && o_disp_ready;
		obs_issue_valid = o_issue_valid;
		obs_disp_ready  = o_disp_ready;
		idle_valid_ok = transferred || o_issue_valid == 2'b00;
		idle_ready_ok = transferred || o_disp_ready == issue_ready; // ready is gated by issue
		stall_ok = issue_ready || !o_disp_ready;
		for (int c = 0; c < 2; c++) begin
			offer_seen[c] = o_issue_valid[c];
			flight_ok[c] = 1'b1;
			col_ok[c]    = 1'b1;
			live_ok[c]   = 1'b1;
			rdy1_ok[c]   = 1'b1;
			rdy2_ok[c]   = 1'b1;
			order_ok[c]  = 1'b1;
			payload_ok[c] = 1'b1;
			if (o_issue_valid[c]) begin
				t = o_issue_ops[c].tag;
				off_tag[c] = t;
				if (!in_flight[t]) begin
					flight_ok[c] = 1'b0;
				end else begin
					off_col[c]  = chain_of[t] % 2; // lanes 0,2 column 0, lanes 1,3 column 1
					off_src1[c] = src1_of[t];
					off_src2[c] = src2_of[t];
					col_ok[c]   = off_col[c] == c;
					live_ok[c]  = (brm_of[t] & br_kill) == '0;
					rdy1_ok[c]  = rdy1_of[t];
					rdy2_ok[c]  = rdy2_of[t];
					order_ok[c] = !older_ready_waiting(t);
					exp_op[c]     = op_of[t];
					got_op[c]     = o_issue_ops[c];
					payload_ok[c] = got_op[c] == exp_op[c];
				end
			end
		end
		// dispatch-time ready bits come from the table before this edge
		for (int k = 0; k < `IQ_DISP_W; k++) begin
			r1[k] = lane_src_ready(k, disp_ops[k].src1);
			r2[k] = lane_src_ready(k, disp_ops[k].src2);
		end
		for (int c = 0; c < 2; c++) begin
			if (o_issue_valid[c] && issue_ready)
				retire_tag(o_issue_ops[c].tag);
		end
		for (int j = 0; j < NTAG; j++) begin
			if (in_flight[j] && (brm_of[j] & br_kill) != '0)
				retire_tag(rob_tag_t'(j));
			if (in_flight[j] && wb_hits(src1_of[j]))
				rdy1_of[j] = 1'b1;
			if (in_flight[j] && wb_hits(src2_of[j]))
				rdy2_of[j] = 1'b1;
		end
		for (int p = 0; p < `IQ_WB_PORTS; p++) begin
			if (wb.valid[p])
				reg_pending[wb.preg[p]] = 1'b0;
		end
		if (fire) begin
			transferred   = 1'b1;
			group_waiting = 1'b0;
			for (int k = 0; k < `IQ_DISP_W; k++) begin
				if (disp_ops[k].valid) begin
					t = disp_ops[k].tag;
					reg_pending[disp_ops[k].dest] = 1'b1; // set even if the lane dies
					if ((disp_ops[k].br_mask & br_kill) != '0) begin
						tag_busy[t] = 1'b0;
					end else begin
						in_flight[t] = 1'b1;
						src1_of[t]   = disp_ops[k].src1;
						src2_of[t]   = disp_ops[k].src2;
						rdy1_of[t]   = r1[k];
						rdy2_of[t]   = r2[k];
						brm_of[t]    = disp_ops[k].br_mask;
						op_of[t].opcode  = disp_ops[k].opcode;
						op_of[t].br_mask = disp_ops[k].br_mask;
						op_of[t].tag     = t;
						op_of[t].dest    = disp_ops[k].dest;
						op_of[t].src1    = disp_ops[k].src1;
						op_of[t].src2    = disp_ops[k].src2;
						chain_of[t]  = k;
						age_of[t]    = disp_seq;
					end
				end
			end
			disp_seq++;
		end
	endtask

	task automatic run_cycle(input logic drain);
		if (drain)
			drive_drain();
		else
			drive_random();
		@(negedge clk);
		observe();
		@(posedge clk);
		#1;
	endtask

	initial begin
		int n;
		arst_n      = 1'b0;
		disp_ops    = '0;
		disp_valid  = 1'b0;
		wb          = '0;
		br_kill     = '0;
		issue_ready = 1'b0;
		lfsr_q      = 32'h4df0;
		reg_pending = '0;
		tag_busy    = '0;
		in_flight   = '0;
		rdy1_of     = '0;
		rdy2_of     = '0;
		disp_seq    = 0;
		group_waiting = 1'b0;
		transferred   = 1'b0;
		offer_seen = '0;
		flight_ok  = '1;
		col_ok     = '1;
		live_ok    = '1;
		rdy1_ok    = '1;
		rdy2_ok    = '1;
		order_ok   = '1;
		payload_ok = '1;
		idle_valid_ok = 1'b1;
		idle_ready_ok = 1'b1;
		stall_ok      = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;

		for (int i = 0; i < RAND_CYCLES; i++)
			run_cycle(1'b0);

		// every producer gets its writeback, then the queue must empty
		while (reg_pending != '0 || group_waiting)
			run_cycle(1'b1);
		n = 0;
		while (inflight_count() != 0 && n < 4 * `IQ_SIZE) begin
			run_cycle(1'b1);
			n++;
		end
		run_cycle(1'b1);

		if (inflight_count() == 0 && o_issue_valid == 2'b00) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			report_failure($sformatf("drain left %0d ops in flight, o_issue_valid is %b",
				inflight_count(), o_issue_valid));
		end
	end

	initial begin
		#(LIMIT_NS);
		report_failure("timeout: the run did not finish within the time limit");
	end

	for (genvar c = 0; c < 2; c++) begin : g_chk
		a_offer_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
			offer_seen[c] |-> flight_ok[c])
			else report_failure($sformatf("column %0d offered tag %0d which is not in flight",
				c, off_tag[c]));

		a_offer_column: assert property (@(posedge clk) disable iff (!arst_n)
			offer_seen[c] |-> col_ok[c])
			else report_failure($sformatf("error %0t o_issue_valid column: expected %0d, got %0d",
				$time, off_col[c], c));

		a_offer_live: assert property (@(posedge clk) disable iff (!arst_n)
			offer_seen[c] |-> live_ok[c])
			else report_failure($sformatf("column %0d offered tag %0d in its kill cycle",
				c, off_tag[c]));

		a_offer_payload: assert property (@(posedge clk) disable iff (!arst_n)
			offer_seen[c] |-> payload_ok[c])
			else report_failure($sformatf("error %0t o_issue_ops[%0d]: expected %h, got %h",
				$time, c, exp_op[c], got_op[c]));

		a_src1_ready: assert property (@(posedge clk) disable iff (!arst_n)
			offer_seen[c] |-> rdy1_ok[c])
			else report_failure($sformatf(
				"error %0t ready of o_issue_ops[%0d].src1 (reg %0d): expected 0, got 1",
				$time, c, off_src1[c]));

		a_src2_ready: assert property (@(posedge clk) disable iff (!arst_n)
			offer_seen[c] |-> rdy2_ok[c])
			else report_failure($sformatf(
				"error %0t ready of o_issue_ops[%0d].src2 (reg %0d): expected 0, got 1",
				$time, c, off_src2[c]));

		a_oldest_first: assert property (@(posedge clk) disable iff (!arst_n)
			offer_seen[c] |-> order_ok[c])
			else report_failure($sformatf(
				"column %0d offered tag %0d while an older ready op waits in its chain",
				c, off_tag[c]));
	end

	a_idle_valid: assert property (@(posedge clk) disable iff (!arst_n) idle_valid_ok)
		else report_failure($sformatf("error %0t o_issue_valid: expected 00, got %b",
			$time, obs_issue_valid));

	a_idle_ready: assert property (@(posedge clk) disable iff (!arst_n) idle_ready_ok)
		else report_failure($sformatf("error %0t o_disp_ready: expected %0b, got %0b",
			$time, !obs_disp_ready, obs_disp_ready));

	a_stall_no_disp: assert property (@(posedge clk) disable iff (!arst_n) stall_ok)
		else report_failure($sformatf("error %0t o_disp_ready: expected 0, got %0b",
			$time, obs_disp_ready));

endmodule

//--- sources.f
+incdir+verilog
+incdir+test
verilog/iq_pkg.sv
verilog/oldest_select.sv
verilog/issue_slot.sv
verilog/issue_queue.sv
verilog/reg_ready_table.sv
verilog/issue_unit.sv
test/tb_issue_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the issue unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f sources.f \
	--top-module tb_issue_unit \
	-o sim_tb_issue_unit
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb_issue_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
echo "pass message not found"
exit 1
